// File: sim.f
+incdir+tests
common/cordic_fmt_pkg.sv
common/cordic_const_pkg.sv
cordic/cordic_quadrant_fold.sv
cordic/cordic_rotation_stage.sv
cordic/cordic_quadrant_unfold.sv
source/sincos_top.sv
tests/sincos_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the sine and cosine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module sincos_tb -f sim.f -o sincos_sim \
  && ./obj_dir/sincos_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0

// File: tests/cordic_ref_model.svh
`ifndef CORDIC_REF_MODEL_SVH
`define CORDIC_REF_MODEL_SVH

////////////////////////////////////////////////////////////
// integer model of the sine and cosine pipeline
////////////////////////////////////////////////////////////

// reciprocal chain gain, scaled by 2^27
localparam logic signed [27:0] ref_gain = 28'sd81503715;

// atan(2^-k), 2^28 phase units per turn
localparam logic signed [27:0] ref_atan [26] = '{
  28'sd33554432, 28'sd19808338, 28'sd10466181, 28'sd5312797,
  28'sd2666708,  28'sd1334654,  28'sd667489,   28'sd333765,
  28'sd166885,   28'sd83442,    28'sd41721,    28'sd20860,
  28'sd10430,    28'sd5215,     28'sd2607,     28'sd1303,
  28'sd651,      28'sd325,      28'sd162,      28'sd81,
  28'sd40,       28'sd20,       28'sd10,       28'sd5,
  28'sd2,        28'sd1
};

function automatic sincos_t model_sincos(input logic [27:0] ph);
  logic signed [27:0] x;
  logic signed [27:0] y;
  logic signed [27:0] z;
  logic signed [27:0] xs;
  logic signed [27:0] ys;
  logic signed [27:0] s;
  logic signed [27:0] c;
  sincos_t            r;
  x = ref_gain;
  y = '0;
  z = {2'b00, ph[25:0]};  // angle inside the quadrant
  for (int k = 0; k < 26; k++)
  begin
    xs = x >>> k;
    ys = y >>> k;
    if (z[27])
    begin
      x = x + ys;
      y = y - xs;
      z = z + ref_atan[k];
    end
    else
    begin
      x = x - ys;
      y = y + xs;
      z = z - ref_atan[k];
    end
  end
  case (ph[27:26])
    2'd0:    s = y;
    2'd1:    s = x;
    2'd2:    s = -y;
    default: s = -x;
  endcase
  case (ph[27:26])
    2'd0:    c = x;
    2'd1:    c = -y;
    2'd2:    c = -x;
    default: c = y;
  endcase
  r.sin = s[27:12];  // truncated, no rounding
  r.cos = c[27:12];
  return r;
endfunction

// galois lfsr, one step per bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0])
    lfsr_next = (s >> 1) ^ 32'hA300_0000;
  else
    lfsr_next = s >> 1;
endfunction

`endif

// File: tests/sincos_tb.sv
`timescale 1ns/100ps

module sincos_tb
  import cordic_fmt_pkg::*;
;

  logic        clk = 1'b0;
  logic        rst_n;
  phase_u      phase;
  logic        in_valid;
  sincos_t     result;
  logic        out_valid;

  logic [31:0] lfsr_state = 32'ha3a5_af15;
  sincos_t     exp_q [$];
  logic [27:0] phase_q [$];
  int          errors = 0;
  int          err_mark = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          in_count = 0;
  int          out_count = 0;
  logic        check_accuracy = 1'b0;

  localparam real two_pi = 6.283185307179586;
  localparam int  latency = 28;  // fold, 26 stages, unfold

  `include "cordic_ref_model.svh"

  sincos_top sincos_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .phase     (phase),
    .in_valid  (in_valid),
    .result    (result),
    .out_valid (out_valid)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [27:0] random_phase();
    logic [31:0] v;
    v = random_bits(28);
    return v[27:0];
  endfunction

  function automatic int round_real(input real r);
    if (r >= 0.0)
      return $rtoi(r + 0.5);
    else
      return -$rtoi(0.5 - r);
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got)
    begin
      $display("Fail %s expected 0x%h got 0x%h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_near(input string name, input logic [27:0] ph,
                            input int exp, input int got);
    if (got - exp > 4 || exp - got > 4)
    begin
      $display("%s is %0d LSB away from the true value %0d at phase 0x%h",
               name, got - exp, exp, ph);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != err_mark)
      tests_failed++;
    $display("test %0d %s done, %0d errors", tests_run, name, errors - err_mark);
    err_mark = errors;
  endtask

  task automatic drive_sample(input logic [27:0] ph);
    @(posedge clk);
    phase.angle <= ph;
    in_valid    <= 1'b1;
    exp_q.push_back(model_sincos(ph));
    phase_q.push_back(ph);
    in_count++;
  endtask

  task automatic drive_idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  task automatic wait_drain(input int limit);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < limit)
    begin
      @(posedge clk);
      in_valid <= 1'b0;
      cycles++;
    end
    if (exp_q.size() != 0)
    begin
      $display("timeout with %0d results still missing", exp_q.size());
      errors++;
      exp_q.delete();
      phase_q.delete();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // output monitor, sampled on the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    sincos_t     exp;
    logic [27:0] ph;
    real         ang;
    if (rst_n && out_valid)
    begin
      out_count++;
      if (exp_q.size() == 0)
      begin
        $display("output valid with no sample in flight");
        errors++;
      end
      else
      begin
        exp = exp_q.pop_front();
        ph  = phase_q.pop_front();
        compare("result.sin", {16'h0, exp.sin}, {16'h0, result.sin});
        compare("result.cos", {16'h0, exp.cos}, {16'h0, result.cos});
        if (check_accuracy)
        begin
          ang = two_pi * real'(ph) / 268435456.0;
          check_near("sin", ph, round_real(32767.0 * $sin(ang)), int'(result.sin));
          check_near("cos", ph, round_real(32767.0 * $cos(ang)), int'(result.cos));
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int   lat;
    int   gap;
    int   n_in;
    int   n_out;
    logic seen;
    rst_n       <= 1'b0;
    phase.angle <= '0;
    in_valid    <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < 40; i++)  // i edges since reset release
    begin
      @(negedge clk);
      compare("out_valid", 32'h0, {31'h0, out_valid});
      if (i < latency)
        compare("result", 32'h0, result);
      else
        compare("result", model_sincos(28'h000_0000), result);  // idle phase 0 still rotates
    end
    end_test("reset state");

    drive_sample(28'h000_0000);
    drive_sample(28'hfff_ffff);
    drive_sample(28'h400_0000);
    drive_sample(28'h3ff_ffff);
    drive_sample(28'h800_0000);
    drive_sample(28'h7ff_ffff);
    drive_sample(28'hc00_0000);
    drive_sample(28'hbff_ffff);
    wait_drain(100);
    end_test("quadrant boundaries");

    drive_sample(random_phase());
    @(posedge clk);  // sample taken on this edge
    in_valid <= 1'b0;
    lat  = 1;  // counted from the drive edge
    seen = 1'b0;
    while (!seen && lat < 60)
    begin
      @(posedge clk);
      lat++;
      @(negedge clk);
      seen = out_valid;
    end
    if (!seen)
    begin
      $display("out_valid never rose after an isolated sample");
      errors++;
    end
    else
    begin
      compare("latency", 32'(latency), 32'(lat));
      @(negedge clk);
      compare("out_valid", 32'h0, {31'h0, out_valid});
    end
    wait_drain(100);
    end_test("fixed latency");

    n_in  = in_count;
    n_out = out_count;
    for (int i = 0; i < 500; i++)
    begin
      drive_sample(random_phase());
      gap = 1 + int'(random_bits(2) % 32'd3);
      drive_idle(gap);
    end
    wait_drain(100);
    compare("out_count", 32'(in_count - n_in), 32'(out_count - n_out));
    end_test("random streaming");

    check_accuracy = 1'b1;
    for (int i = 0; i < 200; i++)
      drive_sample(random_phase());
    wait_drain(100);
    check_accuracy = 1'b0;
    end_test("accuracy");

    $display("tests %0d, failed %0d, errors %0d, samples in %0d, out %0d",
             tests_run, tests_failed, errors, in_count, out_count);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: source/sincos_top.sv
`timescale 1ns/100ps

module sincos_top
  import cordic_fmt_pkg::*;
  import cordic_const_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  phase_u  phase,
  input  logic    in_valid,
  output sincos_t result,
  output logic    out_valid
);

  // entry k feeds rotation stage k, the last one feeds the unfold
  cordic_vec_t stage_vec [0:n_stages];

  ////////////////////////////////////////////////////////////
  // fold, 1 cycle
  ////////////////////////////////////////////////////////////

  cordic_quadrant_fold fold_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .phase    (phase),
    .in_valid (in_valid),
    .vec      (stage_vec[0])
  );

  ////////////////////////////////////////////////////////////
  // rotation chain, one cycle per stage
  ////////////////////////////////////////////////////////////

  for (genvar k = 0; k < n_stages; k++)
  begin : g_stage
    cordic_rotation_stage #(
      .stage (k)
    ) stage_i (
      .clk   (clk),
      .rst_n (rst_n),
      .vin   (stage_vec[k]),
      .vout  (stage_vec[k+1])
    );
  end

  ////////////////////////////////////////////////////////////
  // unfold and output, 1 cycle
  ////////////////////////////////////////////////////////////

  cordic_quadrant_unfold unfold_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .vec       (stage_vec[n_stages]),
    .result    (result),
    .out_valid (out_valid)
  );

endmodule

// File: cordic/cordic_quadrant_unfold.sv
`timescale 1ns/100ps

module cordic_quadrant_unfold
  import cordic_fmt_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  cordic_vec_t vec,
  output sincos_t     result,
  output logic        out_valid
);

  logic signed [phase_w-1:0] sin_full;
  logic signed [phase_w-1:0] cos_full;

  ////////////////////////////////////////////////////////////
  // back to the original quadrant
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (vec.quad)
      2'd0:
      begin
        sin_full = vec.y;
        cos_full = vec.x;
      end
      2'd1:
      begin
        sin_full = vec.x;   // +90 deg
        cos_full = -vec.y;
      end
      2'd2:
      begin
        sin_full = -vec.y;  // +180 deg
        cos_full = -vec.x;
      end
      default:
      begin
        sin_full = -vec.x;  // +270 deg
        cos_full = vec.y;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // output register, truncated
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      result    <= '0;
      out_valid <= 1'b0;
    end
    else
    begin
      result.sin <= sin_full[phase_w-1 -: out_w];
      result.cos <= cos_full[phase_w-1 -: out_w];
      out_valid  <= vec.valid;
    end
  end

endmodule

// File: cordic/cordic_rotation_stage.sv
`timescale 1ns/100ps

module cordic_rotation_stage
  import cordic_fmt_pkg::*;
  import cordic_const_pkg::*;
#(
  parameter int stage = 0
)
(
  input  logic        clk,
  input  logic        rst_n,
  input  cordic_vec_t vin,
  output cordic_vec_t vout
);

  logic signed [phase_w-1:0] x_sh;
  logic signed [phase_w-1:0] y_sh;
  logic                      z_neg;
  cordic_vec_t               nxt;

  ////////////////////////////////////////////////////////////
  // shift and direction
  ////////////////////////////////////////////////////////////

  // arithmetic shift keeps the sign of x and y
  assign x_sh  = $signed(vin.x) >>> stage;
  assign y_sh  = $signed(vin.y) >>> stage;

  assign z_neg = vin.z[phase_w-1];  // rotate back when z went negative

  always_comb
  begin
    if (!z_neg)
    begin
      nxt.x = vin.x - y_sh;
      nxt.y = vin.y + x_sh;
      nxt.z = vin.z - atan_table[stage];
    end
    else
    begin
      nxt.x = vin.x + y_sh;
      nxt.y = vin.y - x_sh;
      nxt.z = vin.z + atan_table[stage];
    end

    nxt.quad  = vin.quad;
    nxt.valid = vin.valid;  // never gates the data
  end

  ////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      vout <= '0;
    end
    else
    begin
      vout <= nxt;
    end
  end

endmodule

// File: cordic/cordic_quadrant_fold.sv
`timescale 1ns/100ps

module cordic_quadrant_fold
  import cordic_fmt_pkg::*;
  import cordic_const_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  phase_u      phase,
  input  logic        in_valid,
  output cordic_vec_t vec
);

  cordic_vec_t start_vec;

  ////////////////////////////////////////////////////////////
  // start vector
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    // pre-scaled by the chain gain so the result lands on unit length
    start_vec.x     = cordic_gain;
    start_vec.y     = '0;

    // quadrant bits cleared, z stays in [0, 90) degrees
    start_vec.z     = {{quad_w{1'b0}}, phase.split.resid};

    start_vec.quad  = phase.split.quad;
    start_vec.valid = in_valid;
  end

  ////////////////////////////////////////////////////////////
  // fold register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      vec <= '0;
    end
    else
    begin
      vec <= start_vec;
    end
  end

endmodule

// File: common/cordic_const_pkg.sv
package cordic_const_pkg;

  import cordic_fmt_pkg::*;

  // one micro-rotation per stage
  localparam int n_stages = 26;

  // 1/K of the rotation chain, about 0.60725 * 2^27
  localparam logic [phase_w-1:0] cordic_gain = 28'd81503715;

  ////////////////////////////////////////////////////////////
  // atan(2^-k) in phase units, 2^28 per turn
  ////////////////////////////////////////////////////////////

  localparam logic [phase_w-1:0] atan_table [n_stages] = '{
    28'd33554432,  // 45 deg
    28'd19808338,
    28'd10466181,
    28'd5312797,
    28'd2666708,
    28'd1334654,
    28'd667489,
    28'd333765,
    28'd166885,
    28'd83442,
    28'd41721,
    28'd20860,
    28'd10430,
    28'd5215,
    28'd2607,
    28'd1303,
    28'd651,
    28'd325,
    28'd162,
    28'd81,
    28'd40,
    28'd20,
    28'd10,
    28'd5,
    28'd2,
    28'd1
  };

endpackage

// File: common/cordic_fmt_pkg.sv
package cordic_fmt_pkg;

  ////////////////////////////////////////////////////////////
  // word widths
  ////////////////////////////////////////////////////////////

  // one full turn spans the whole phase word
  localparam int phase_w = 28;

  localparam int out_w   = 16;  // top bits of x and y
  localparam int quad_w  = 2;

  // angle left over once the quadrant is stripped
  localparam int resid_w = phase_w - quad_w;

  ////////////////////////////////////////////////////////////
  // phase word, read whole or split
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [quad_w-1:0]  quad;   // 90 degree sector
    logic [resid_w-1:0] resid;  // angle inside the sector
  } phase_split_t;

  typedef union packed {
    logic [phase_w-1:0] angle;
    phase_split_t       split;
  } phase_u;

  ////////////////////////////////////////////////////////////
  // pipeline word and result
  ////////////////////////////////////////////////////////////

  // x, y and z are two's complement
  typedef struct packed {
    logic signed [phase_w-1:0] x;
    logic signed [phase_w-1:0] y;
    logic signed [phase_w-1:0] z;
    logic [quad_w-1:0]         quad;   // rides along to the unfold
    logic                      valid;  // marks a real sample
  } cordic_vec_t;

  typedef struct packed {
    logic signed [out_w-1:0] sin;
    logic signed [out_w-1:0] cos;
  } sincos_t;

endpackage
